/* common/rv32_pipe_pkg.sv */
// Pipeline control definitions
// Stage buffer layouts, operand selectors and the bubble control word
`default_nettype none

package rv32_pipe_pkg;

    import rv32_types::*;

    typedef enum logic [1:0] {
        BYPASS_NONE, BYPASS_EXEC_BUFF, BYPASS_MEM_BUFF
    } bypass_sel_e;

    typedef enum logic [2:0] {
        ALU_IN_REG_1, ALU_IN_REG_2, ALU_IN_PC, ALU_IN_IMM, ALU_IN_ZERO
    } alu_in_sel_e;

    typedef enum logic [1:0] {
        WB_NONE, WB_PC4, WB_INT_ALU
    } wb_src_e;

    typedef struct packed {
        logic             valid;
        rv32_instr_type_e t;
        rv32_reg_idx      rd;
        bypass_sel_e      bypass_rs1;
        bypass_sel_e      bypass_rs2;
        alu_in_sel_e      alu_in1;
        alu_in_sel_e      alu_in2;
        int_alu_op_e      int_alu_op;
        branch_op_e       branch_op;
        wb_src_e          wb_src;
    } decoded_instr_t;

    typedef struct packed {
        rv32_word       instr;
        rv32_word       pc;
        decoded_instr_t decoded_instr;
        rv32_word       reg1;
        rv32_word       reg2;
    } decode_exec_buffer_t;

    typedef struct packed {
        rv32_word       instr;
        rv32_word       pc;
        decoded_instr_t decoded_instr;
        rv32_word       wb_result;
    } exec_mem_buffer_t;

    // Control word of a bubble, writes nothing and never jumps
    function automatic decoded_instr_t create_nop_ctrl();
        decoded_instr_t ctrl;
        ctrl.valid      = 1'b0;
        ctrl.t          = TYPE_I;
        ctrl.rd         = '0;
        ctrl.bypass_rs1 = BYPASS_NONE;
        ctrl.bypass_rs2 = BYPASS_NONE;
        ctrl.alu_in1    = ALU_IN_ZERO;
        ctrl.alu_in2    = ALU_IN_ZERO;
        ctrl.int_alu_op = INT_ADD;
        ctrl.branch_op  = BR_NONE;
        ctrl.wb_src     = WB_NONE;
        return ctrl;
    endfunction

endpackage

`default_nettype wire

/* common/rv32_types.sv */
// RV32I base definitions
// Machine word, register index, opcode and operation encodings
`default_nettype none

package rv32_types;

    typedef logic [31:0] rv32_word;
    typedef logic [4:0]  rv32_reg_idx;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } rv32_opcode_e;

    typedef enum logic [2:0] {
        TYPE_R, TYPE_I, TYPE_S, TYPE_B, TYPE_U, TYPE_J
    } rv32_instr_type_e;

    typedef enum logic [3:0] {
        INT_ADD, INT_SUB, INT_SLL, INT_SLT, INT_SLTU,
        INT_XOR, INT_SRL, INT_SRA, INT_OR, INT_AND
    } int_alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_JUMP, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } branch_op_e;

    // addi x0, x0, 0
    localparam rv32_word RV_NOP = 32'h0000_0013;

endpackage

`default_nettype wire

/* decode/rv32_decode_stage.sv */
// Decode stage
// Decodes the incoming instruction, reads the register file, picks
// forwarding sources and holds the decode-to-execute buffer
`timescale 1ns/100ps
`default_nettype none

module rv32_decode_stage (
    input  logic                              clk,
    input  logic                              resetn,
    input  rv32_types::rv32_word              instr_in,
    input  rv32_types::rv32_word              pc_in,
    input  logic                              instr_valid,
    input  logic                              stop,
    input  logic                              do_jump,
    input  rv32_pipe_pkg::exec_mem_buffer_t   exec_mem_buff,
    input  rv32_types::rv32_word              rs1_data,
    input  rv32_types::rv32_word              rs2_data,
    output rv32_types::rv32_reg_idx           rs1_addr,
    output rv32_types::rv32_reg_idx           rs2_addr,
    output rv32_pipe_pkg::decode_exec_buffer_t decode_exec_buff
);

    import rv32_types::*;
    import rv32_pipe_pkg::*;

    logic [2:0]          funct3;
    logic [6:0]          funct7;
    decoded_instr_t      ctrl;
    decode_exec_buffer_t next_buff;

    assign funct3   = instr_in[14:12];
    assign funct7   = instr_in[31:25];
    assign rs1_addr = instr_in[19:15];
    assign rs2_addr = instr_in[24:20];

    function automatic int_alu_op_e f3_alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? INT_SUB : INT_ADD;
            3'b001:  return INT_SLL;
            3'b010:  return INT_SLT;
            3'b011:  return INT_SLTU;
            3'b100:  return INT_XOR;
            3'b101:  return alt ? INT_SRA : INT_SRL;
            3'b110:  return INT_OR;
            default: return INT_AND;
        endcase
    endfunction

    always_comb begin
        ctrl       = create_nop_ctrl();
        ctrl.valid = 1'b1;
        ctrl.rd    = instr_in[11:7];
        case (instr_in[6:0])
            OPC_OP: begin
                ctrl.t          = TYPE_R;
                ctrl.alu_in1    = ALU_IN_REG_1;
                ctrl.alu_in2    = ALU_IN_REG_2;
                ctrl.int_alu_op = f3_alu_op(funct3, funct7[5]);
                ctrl.wb_src     = WB_INT_ALU;
                // Only SUB and SRA use the alternate funct7
                if (funct7 != 7'b0 &&
                    !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    ctrl.valid = 1'b0;
                end
            end
            OPC_OP_IMM: begin
                ctrl.t          = TYPE_I;
                ctrl.alu_in1    = ALU_IN_REG_1;
                ctrl.alu_in2    = ALU_IN_IMM;
                ctrl.int_alu_op = f3_alu_op(funct3, funct3 == 3'b101 && funct7[5]);
                ctrl.wb_src     = WB_INT_ALU;
                if ((funct3 == 3'b001 && funct7 != 7'b0) ||
                    (funct3 == 3'b101 && funct7 != 7'b0 && funct7 != 7'b0100000)) begin
                    ctrl.valid = 1'b0;
                end
            end
            OPC_LUI, OPC_AUIPC: begin
                ctrl.t       = TYPE_U;
                ctrl.alu_in1 = (instr_in[6:0] == OPC_LUI) ? ALU_IN_ZERO : ALU_IN_PC;
                ctrl.alu_in2 = ALU_IN_IMM;
                ctrl.wb_src  = WB_INT_ALU;
            end
            OPC_JAL: begin
                ctrl.t         = TYPE_J;
                ctrl.alu_in1   = ALU_IN_PC;
                ctrl.alu_in2   = ALU_IN_IMM;
                ctrl.branch_op = BR_JUMP;
                ctrl.wb_src    = WB_PC4;
            end
            OPC_JALR: begin
                ctrl.t         = TYPE_I;
                ctrl.alu_in1   = ALU_IN_REG_1;
                ctrl.alu_in2   = ALU_IN_IMM;
                ctrl.branch_op = BR_JUMP;
                ctrl.wb_src    = WB_PC4;
                ctrl.valid     = (funct3 == 3'b000);
            end
            OPC_BRANCH: begin
                ctrl.t       = TYPE_B;
                ctrl.rd      = '0;
                ctrl.alu_in1 = ALU_IN_PC;
                ctrl.alu_in2 = ALU_IN_IMM;
                case (funct3)
                    3'b000:  ctrl.branch_op = BR_BEQ;
                    3'b001:  ctrl.branch_op = BR_BNE;
                    3'b100:  ctrl.branch_op = BR_BLT;
                    3'b101:  ctrl.branch_op = BR_BGE;
                    3'b110:  ctrl.branch_op = BR_BLTU;
                    3'b111:  ctrl.branch_op = BR_BGEU;
                    default: ctrl.valid = 1'b0;
                endcase
            end
            default: ctrl.valid = 1'b0;
        endcase

        // Unknown encodings become bubbles
        if (!ctrl.valid) begin
            ctrl = create_nop_ctrl();
        end

        // Nearer producer is checked last so it wins
        ctrl.bypass_rs1 = BYPASS_NONE;
        ctrl.bypass_rs2 = BYPASS_NONE;
        if (exec_mem_buff.decoded_instr.valid && exec_mem_buff.decoded_instr.rd != 5'd0) begin
            if (exec_mem_buff.decoded_instr.rd == rs1_addr) ctrl.bypass_rs1 = BYPASS_MEM_BUFF;
            if (exec_mem_buff.decoded_instr.rd == rs2_addr) ctrl.bypass_rs2 = BYPASS_MEM_BUFF;
        end
        if (decode_exec_buff.decoded_instr.valid && decode_exec_buff.decoded_instr.rd != 5'd0) begin
            if (decode_exec_buff.decoded_instr.rd == rs1_addr) ctrl.bypass_rs1 = BYPASS_EXEC_BUFF;
            if (decode_exec_buff.decoded_instr.rd == rs2_addr) ctrl.bypass_rs2 = BYPASS_EXEC_BUFF;
        end

        next_buff.instr         = instr_in;
        next_buff.pc            = pc_in;
        next_buff.decoded_instr = ctrl;
        next_buff.reg1          = rs1_data;
        next_buff.reg2          = rs2_data;
        // Squashed or missing fetch enters as a bubble
        if (do_jump || !instr_valid) begin
            next_buff.instr         = RV_NOP;
            next_buff.decoded_instr = create_nop_ctrl();
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            decode_exec_buff.instr         <= RV_NOP;
            decode_exec_buff.pc            <= '0;
            decode_exec_buff.decoded_instr <= create_nop_ctrl();
            decode_exec_buff.reg1          <= '0;
            decode_exec_buff.reg2          <= '0;
        end else if (!stop) begin
            decode_exec_buff <= next_buff;
        end
    end

endmodule

`default_nettype wire

/* decode/rv32_regfile.sv */
// Integer register file
// 32 registers, two asynchronous read ports and one write port, x0 reads zero
`timescale 1ns/100ps
`default_nettype none

module rv32_regfile (
    input  logic                    clk,
    input  logic                    resetn,
    input  rv32_types::rv32_reg_idx rs1_addr,
    input  rv32_types::rv32_reg_idx rs2_addr,
    input  logic                    wr_en,
    input  rv32_types::rv32_reg_idx wr_addr,
    input  rv32_types::rv32_word    wr_data,
    output rv32_types::rv32_word    rs1_data,
    output rv32_types::rv32_word    rs2_data
);

    import rv32_types::*;

    rv32_word regs [32];

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int idx = 0; idx < 32; idx++) begin
                regs[idx] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* exec/rv32_exec_stage.sv */
// Execute stage
// Forwards operands, runs the ALU, resolves branches and jumps and
// holds the execute-to-result buffer
`timescale 1ns/100ps
`default_nettype none

module rv32_exec_stage (
    input  logic                               clk,
    input  logic                               resetn,
    input  rv32_pipe_pkg::decode_exec_buffer_t decode_exec_buff,
    input  logic                               stop,
    input  rv32_types::rv32_word               wb_bypass,
    output rv32_pipe_pkg::exec_mem_buffer_t    exec_mem_buff,
    output logic                               do_jump,
    output rv32_types::rv32_word               jump_addr
);

    import rv32_types::*;
    import rv32_pipe_pkg::*;

    decoded_instr_t   ctrl;
    rv32_word         reg1_data;
    rv32_word         reg2_data;
    rv32_word         immediate;
    rv32_word         alu_a;
    rv32_word         alu_b;
    rv32_word         alu_result;
    exec_mem_buffer_t next_buff;

    assign ctrl = decode_exec_buff.decoded_instr;

    function automatic rv32_word forward(input bypass_sel_e sel, input rv32_word reg_val,
                                         input rv32_word exec_val, input rv32_word mem_val);
        case (sel)
            BYPASS_EXEC_BUFF: return exec_val;
            BYPASS_MEM_BUFF:  return mem_val;
            default:          return reg_val;
        endcase
    endfunction

    function automatic rv32_word alu_input(input alu_in_sel_e sel, input rv32_word r1,
                                           input rv32_word r2, input rv32_word pc,
                                           input rv32_word imm);
        case (sel)
            ALU_IN_REG_1: return r1;
            ALU_IN_REG_2: return r2;
            ALU_IN_PC:    return pc;
            ALU_IN_IMM:   return imm;
            default:      return '0;
        endcase
    endfunction

    assign reg1_data = forward(ctrl.bypass_rs1, decode_exec_buff.reg1,
                               exec_mem_buff.wb_result, wb_bypass);
    assign reg2_data = forward(ctrl.bypass_rs2, decode_exec_buff.reg2,
                               exec_mem_buff.wb_result, wb_bypass);

    rv32_immediate_gen i_imm_gen (
        .instr_type  (ctrl.t),
        .instruction (decode_exec_buff.instr),
        .immediate   (immediate)
    );

    assign alu_a = alu_input(ctrl.alu_in1, reg1_data, reg2_data, decode_exec_buff.pc, immediate);
    assign alu_b = alu_input(ctrl.alu_in2, reg1_data, reg2_data, decode_exec_buff.pc, immediate);

    rv32_int_alu i_alu (
        .op1    (alu_a),
        .op2    (alu_b),
        .opsel  (ctrl.int_alu_op),
        .result (alu_result)
    );

    always_comb begin
        case (ctrl.branch_op)
            BR_JUMP: do_jump = 1'b1;
            BR_BEQ:  do_jump = (reg1_data == reg2_data);
            BR_BNE:  do_jump = (reg1_data != reg2_data);
            BR_BLT:  do_jump = ($signed(reg1_data) < $signed(reg2_data));
            BR_BGE:  do_jump = ($signed(reg1_data) >= $signed(reg2_data));
            BR_BLTU: do_jump = (reg1_data < reg2_data);
            BR_BGEU: do_jump = (reg1_data >= reg2_data);
            default: do_jump = 1'b0;
        endcase
    end

    // JALR target drops bit 0
    assign jump_addr = (decode_exec_buff.instr[6:0] == OPC_JALR) ?
                       {alu_result[31:1], 1'b0} : alu_result;

    always_comb begin
        next_buff.instr         = decode_exec_buff.instr;
        next_buff.pc            = decode_exec_buff.pc;
        next_buff.decoded_instr = ctrl;
        case (ctrl.wb_src)
            WB_PC4:     next_buff.wb_result = decode_exec_buff.pc + 32'd4;
            WB_INT_ALU: next_buff.wb_result = alu_result;
            default:    next_buff.wb_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exec_mem_buff.instr         <= RV_NOP;
            exec_mem_buff.pc            <= '0;
            exec_mem_buff.decoded_instr <= create_nop_ctrl();
            exec_mem_buff.wb_result     <= '0;
        end else if (!stop) begin
            exec_mem_buff <= next_buff;
        end
    end

endmodule

`default_nettype wire

/* exec/rv32_immediate_gen.sv */
// Immediate generator
// Sign-extended immediate for each RV32I instruction format
`timescale 1ns/100ps
`default_nettype none

module rv32_immediate_gen (
    input  rv32_types::rv32_instr_type_e instr_type,
    input  rv32_types::rv32_word         instruction,
    output rv32_types::rv32_word         immediate
);

    import rv32_types::*;

    rv32_word in;

    assign in = instruction;

    always_comb begin
        case (instr_type)
            TYPE_I:  immediate = {{21{in[31]}}, in[30:20]};
            TYPE_S:  immediate = {{21{in[31]}}, in[30:25], in[11:7]};
            TYPE_B:  immediate = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
            TYPE_U:  immediate = {in[31:12], 12'b0};
            TYPE_J:  immediate = {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
            default: immediate = '0;
        endcase
    end

endmodule

`default_nettype wire

/* exec/rv32_int_alu.sv */
// Integer ALU
// The ten RV32I arithmetic, logic, compare and shift operations
`timescale 1ns/100ps
`default_nettype none

module rv32_int_alu (
    input  rv32_types::rv32_word    op1,
    input  rv32_types::rv32_word    op2,
    input  rv32_types::int_alu_op_e opsel,
    output rv32_types::rv32_word    result
);

    import rv32_types::*;

    logic [4:0] shamt;

    assign shamt = op2[4:0];

    always_comb begin
        case (opsel)
            INT_ADD:  result = op1 + op2;
            INT_SUB:  result = op1 - op2;
            INT_SLL:  result = op1 << shamt;
            INT_SLT:  result = {31'b0, $signed(op1) < $signed(op2)};
            INT_SLTU: result = {31'b0, op1 < op2};
            INT_XOR:  result = op1 ^ op2;
            INT_SRL:  result = op1 >> shamt;
            INT_SRA:  result = $unsigned($signed(op1) >>> shamt);
            INT_OR:   result = op1 | op2;
            INT_AND:  result = op1 & op2;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* project.f */
common/rv32_types.sv
common/rv32_pipe_pkg.sv
exec/rv32_immediate_gen.sv
exec/rv32_int_alu.sv
exec/rv32_exec_stage.sv
decode/rv32_regfile.sv
decode/rv32_decode_stage.sv
verilog/rv32_result_stage.sv
verilog/rv32_pipe_top.sv
test/rv32_pipe_chk.sv
test/rv32_pipe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module rv32_pipe_tb \
    --Mdir obj_dir -o sim_rv32 > build.log 2>&1 \
    && ./obj_dir/sim_rv32 > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log
grep -q "^Simulation passed$" sim.log && exit 0 || exit 1

/* test/rv32_pipe_chk.sv */
// Pipeline protocol checks
// Bound to the top level, watches reset, stop and jump outputs
`timescale 1ns/100ps
`default_nettype none

module rv32_pipe_chk (
    input logic                 clk,
    input logic                 resetn,
    input logic                 stop,
    input logic                 do_jump,
    input rv32_types::rv32_word jump_addr,
    input logic                 retire_valid,
    input rv32_types::rv32_word retire_pc,
    input rv32_types::rv32_word retire_data
);

    // First cycle out of reset has empty buffers
    property quiet_after_reset;
        @(posedge clk) (resetn && !$past(resetn)) |-> (!retire_valid && !do_jump);
    endproperty

    // Stopped cycle reports nothing and keeps its record for later
    property no_retire_in_stop;
        @(posedge clk) disable iff (!resetn)
            ($past(resetn) && $past(stop)) |->
                (!$past(retire_valid) && $stable(retire_pc) && $stable(retire_data));
    endproperty

    property jump_target_even;
        @(posedge clk) disable iff (!resetn) do_jump |-> !jump_addr[0];
    endproperty

    a_quiet_after_reset: assert property (quiet_after_reset);
    a_no_retire_in_stop: assert property (no_retire_in_stop);
    a_jump_target_even:  assert property (jump_target_even);

endmodule

bind rv32_pipe_top rv32_pipe_chk i_chk (
    .clk          (clk),
    .resetn       (resetn),
    .stop         (stop),
    .do_jump      (do_jump),
    .jump_addr    (jump_addr),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_data  (retire_data)
);

`default_nettype wire

/* test/rv32_pipe_golden.txt */
// Test count, then per test: id, program length, retire count, stop flag
// Program as address/word pairs, then retire records as pc, rd, data
5
// ALU ops, LUI and AUIPC
1 6 6 0
0 00500093 4 FFD00113 8 123451B7 c 00001217 10 0F004293 14 05506313
0 1 5  4 2 FFFFFFFD  8 3 12345000  c 4 100C  10 5 F0  14 6 55
// Forwarding chains
2 6 6 0
0 00700093 4 00308113 8 002081B3 c 40118233 10 001212B3 14 00513333
0 1 7  4 2 A  8 3 11  c 4 A  10 5 500  14 6 1
// Branches, JAL and JALR
3 10 7 0
0 00100093 4 00008463 8 00009463 c 06300113 10 008001EF
14 00100213 18 00D182E7 1c 00500313 20 00105463 24 00128393
0 1 1  4 0 0  8 0 0  10 3 14  18 5 1C  20 0 0  24 7 1D
// Forwarding chains under random stop
4 6 6 1
0 00700093 4 00308113 8 002081B3 c 40118233 10 001212B3 14 00513333
0 1 7  4 2 A  8 3 11  c 4 A  10 5 500  14 6 1
// Writes to x0
5 4 4 0
0 00500013 4 000000B3 8 00300113 c 000161B3
0 0 5  4 1 0  8 2 3  c 3 3

/* test/rv32_pipe_tb.sv */
// RV32I pipeline testbench
// Instruction memory model, golden program runner and retire checker
`timescale 1ns/100ps
`default_nettype none

module rv32_pipe_tb;

    import rv32_types::*;

    logic        clk = 1'b0;
    logic        resetn = 1'b0;
    rv32_word    instr_in = RV_NOP;
    rv32_word    pc_in = '0;
    logic        instr_valid = 1'b0;
    logic        stop = 1'b0;
    logic        do_jump;
    rv32_word    jump_addr;
    logic        retire_valid;
    rv32_word    retire_pc;
    rv32_reg_idx retire_rd;
    rv32_word    retire_data;

    rv32_word    golden [256];
    rv32_word    imem [256];
    bit          imem_ok [256];
    rv32_word    exp_pc [32];
    rv32_reg_idx exp_rd [32];
    rv32_word    exp_data [32];

    int          n_exp = 0;
    int          ret_idx = 0;
    int          accepted = 0;
    int          errors = 0;
    int          checks = 0;
    int          cur_id = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;
    int          stop_budget = 0;
    bit          stop_en = 1'b0;
    bit          running = 1'b0;
    rv32_word    fetch_pc = '0;

    rv32_pipe_top i_dut (
        .clk          (clk),
        .resetn       (resetn),
        .instr_in     (instr_in),
        .pc_in        (pc_in),
        .instr_valid  (instr_valid),
        .stop         (stop),
        .do_jump      (do_jump),
        .jump_addr    (jump_addr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #4 clk = ~clk;

    // Fetch side, bubbles outside the program
    always @(negedge clk) begin
        if (running) begin
            pc_in       = fetch_pc;
            instr_valid = fetch_pc < 32'd1024 && fetch_pc[1:0] == 2'b00 &&
                          imem_ok[fetch_pc[9:2]];
            instr_in    = instr_valid ? imem[fetch_pc[9:2]] : RV_NOP;
            if (stop_en && stop_budget > 0 && ($urandom % 4) == 0) begin
                stop        = 1'b1;
                stop_budget = stop_budget - 1;
            end else begin
                stop = 1'b0;
            end
        end else begin
            pc_in       = '0;
            instr_valid = 1'b0;
            instr_in    = RV_NOP;
            stop        = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout in test %0d after %0d cycles, %0d of %0d retires seen",
                     cur_id, cycle_count, ret_idx, n_exp);
            $display("Simulation failed");
            $finish;
        end
        if (running && retire_valid) begin
            checks = checks + 1;
            assert (accepted > 0) else begin
                $display("Retire seen before any instruction was accepted");
                errors = errors + 1;
            end
            assert (!stop) else begin
                $display("Retire seen while stop was high");
                errors = errors + 1;
            end
            assert (ret_idx < n_exp) else begin
                $display("Extra retire at pc %h in test %0d", retire_pc, cur_id);
                errors = errors + 1;
            end
            if (ret_idx < n_exp) begin
                assert (retire_pc == exp_pc[ret_idx]) else begin
                    $display("Fail retire_pc: got %h expected %h", retire_pc, exp_pc[ret_idx]);
                    errors = errors + 1;
                end
                assert (retire_rd == exp_rd[ret_idx]) else begin
                    $display("Fail retire_rd: got %h expected %h", retire_rd, exp_rd[ret_idx]);
                    errors = errors + 1;
                end
                assert (retire_data == exp_data[ret_idx]) else begin
                    $display("Fail retire_data: got %h expected %h",
                             retire_data, exp_data[ret_idx]);
                    errors = errors + 1;
                end
            end
            ret_idx = ret_idx + 1;
        end
        // Redirect after a taken jump, the fetched word is dropped
        if (running && !stop) begin
            if (instr_valid && !do_jump) begin
                accepted = accepted + 1;
            end
            if (do_jump) begin
                fetch_pc <= jump_addr;
            end else if (instr_valid) begin
                fetch_pc <= fetch_pc + 32'd4;
            end
        end else if (!running) begin
            fetch_pc <= '0;
        end
    end

    // Counts in the golden file are written as decimal digits
    function automatic int decode_decimal(input rv32_word digits);
        int value;
        value = 0;
        for (int i = 7; i >= 0; i--) begin
            value = value * 10 + int'(digits[4*i +: 4]);
        end
        return value;
    endfunction

    task automatic run_test(inout int ptr);
        int n_prog;
        int start_errors;
        bit stop_flag;
        cur_id    = decode_decimal(golden[ptr]);
        n_prog    = decode_decimal(golden[ptr + 1]);
        stop_flag = golden[ptr + 3][0];
        n_exp     = decode_decimal(golden[ptr + 2]);
        ptr       = ptr + 4;
        for (int i = 0; i < 256; i++) begin
            imem_ok[i] = 1'b0;
        end
        for (int i = 0; i < n_prog; i++) begin
            imem[golden[ptr][9:2]]    = golden[ptr + 1];
            imem_ok[golden[ptr][9:2]] = 1'b1;
            ptr = ptr + 2;
        end
        for (int i = 0; i < n_exp; i++) begin
            exp_pc[i]   = golden[ptr];
            exp_rd[i]   = golden[ptr + 1][4:0];
            exp_data[i] = golden[ptr + 2];
            ptr = ptr + 3;
        end
        start_errors = errors;
        @(negedge clk);
        resetn = 1'b0;
        #1 running = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        #1;
        accepted    = 0;
        ret_idx     = 0;
        stop_budget = 2 * n_exp;
        stop_en     = stop_flag;
        running     = 1'b1;
        while (ret_idx < n_exp) begin
            @(posedge clk);
        end
        // Drain so that a late extra retire is caught
        repeat (6) @(posedge clk);
        @(negedge clk);
        #1 running = 1'b0;
        $display("Test %0d: %0d retires, %0d errors", cur_id, ret_idx, errors - start_errors);
    endtask

    initial begin
        int seed;
        int n_tests;
        int ptr;
        seed = $urandom(32'hc904_01c6);
        $readmemh("test/rv32_pipe_golden.txt", golden);
        n_tests     = decode_decimal(golden[0]);
        ptr         = 1;
        cycle_limit = 0;
        for (int t = 0; t < n_tests; t++) begin
            cycle_limit = cycle_limit + 4 * decode_decimal(golden[ptr + 2]) + 20;
            ptr = ptr + 4 + 2 * decode_decimal(golden[ptr + 1]) +
                  3 * decode_decimal(golden[ptr + 2]);
        end
        ptr = 1;
        for (int t = 0; t < n_tests; t++) begin
            run_test(ptr);
        end
        $display("%0d tests, %0d retires checked, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/rv32_pipe_top.sv */
// RV32I pipeline top level
// Decode, execute and result stages around the register file
`timescale 1ns/100ps
`default_nettype none

module rv32_pipe_top (
    input  logic                    clk,
    input  logic                    resetn,
    input  rv32_types::rv32_word    instr_in,
    input  rv32_types::rv32_word    pc_in,
    input  logic                    instr_valid,
    input  logic                    stop,
    output logic                    do_jump,
    output rv32_types::rv32_word    jump_addr,
    output logic                    retire_valid,
    output rv32_types::rv32_word    retire_pc,
    output rv32_types::rv32_reg_idx retire_rd,
    output rv32_types::rv32_word    retire_data
);

    import rv32_types::*;
    import rv32_pipe_pkg::*;

    decode_exec_buffer_t decode_exec_buff;
    exec_mem_buffer_t    exec_mem_buff;
    rv32_reg_idx         rs1_addr;
    rv32_reg_idx         rs2_addr;
    rv32_word            rs1_data;
    rv32_word            rs2_data;
    rv32_word            wb_bypass;
    logic                rf_wr_en;
    rv32_reg_idx         rf_wr_addr;
    rv32_word            rf_wr_data;

    rv32_decode_stage i_decode (
        .clk              (clk),
        .resetn           (resetn),
        .instr_in         (instr_in),
        .pc_in            (pc_in),
        .instr_valid      (instr_valid),
        .stop             (stop),
        .do_jump          (do_jump),
        .exec_mem_buff    (exec_mem_buff),
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data),
        .rs1_addr         (rs1_addr),
        .rs2_addr         (rs2_addr),
        .decode_exec_buff (decode_exec_buff)
    );

    rv32_regfile i_regfile (
        .clk      (clk),
        .resetn   (resetn),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wr_en    (rf_wr_en),
        .wr_addr  (rf_wr_addr),
        .wr_data  (rf_wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv32_exec_stage i_exec (
        .clk              (clk),
        .resetn           (resetn),
        .decode_exec_buff (decode_exec_buff),
        .stop             (stop),
        .wb_bypass        (wb_bypass),
        .exec_mem_buff    (exec_mem_buff),
        .do_jump          (do_jump),
        .jump_addr        (jump_addr)
    );

    // Result rd stays internal, the register file already holds that value
    rv32_result_stage i_result (
        .clk           (clk),
        .resetn        (resetn),
        .stop          (stop),
        .exec_mem_buff (exec_mem_buff),
        .wb_bypass     (wb_bypass),
        .wb_rd         (),
        .rf_wr_en      (rf_wr_en),
        .rf_wr_addr    (rf_wr_addr),
        .rf_wr_data    (rf_wr_data),
        .retire_valid  (retire_valid),
        .retire_pc     (retire_pc),
        .retire_rd     (retire_rd),
        .retire_data   (retire_data)
    );

endmodule

`default_nettype wire

/* verilog/rv32_result_stage.sv */
// Result stage
// Holds the last pipeline buffer, writes the register file and
// reports every retired instruction
`timescale 1ns/100ps
`default_nettype none

module rv32_result_stage (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            stop,
    input  rv32_pipe_pkg::exec_mem_buffer_t exec_mem_buff,
    output rv32_types::rv32_word            wb_bypass,
    output rv32_types::rv32_reg_idx         wb_rd,
    output logic                            rf_wr_en,
    output rv32_types::rv32_reg_idx         rf_wr_addr,
    output rv32_types::rv32_word            rf_wr_data,
    output logic                            retire_valid,
    output rv32_types::rv32_word            retire_pc,
    output rv32_types::rv32_reg_idx         retire_rd,
    output rv32_types::rv32_word            retire_data
);

    import rv32_types::*;
    import rv32_pipe_pkg::*;

    exec_mem_buffer_t result_buff;
    logic             writes_rd;

    // Write happens on the edge that moves the instruction in here
    assign rf_wr_en   = !stop && exec_mem_buff.decoded_instr.valid &&
                        exec_mem_buff.decoded_instr.wb_src != WB_NONE;
    assign rf_wr_addr = exec_mem_buff.decoded_instr.rd;
    assign rf_wr_data = exec_mem_buff.wb_result;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            result_buff.instr         <= RV_NOP;
            result_buff.pc            <= '0;
            result_buff.decoded_instr <= create_nop_ctrl();
            result_buff.wb_result     <= '0;
        end else if (!stop) begin
            result_buff <= exec_mem_buff;
        end
    end

    assign writes_rd = result_buff.decoded_instr.valid &&
                       result_buff.decoded_instr.wb_src != WB_NONE;
    assign wb_bypass = result_buff.wb_result;
    assign wb_rd     = writes_rd ? result_buff.decoded_instr.rd : '0;

    // Buffer holds through a stop, so the report waits for it to end
    assign retire_valid = result_buff.decoded_instr.valid && !stop;
    assign retire_pc    = result_buff.pc;
    assign retire_rd    = wb_rd;
    assign retire_data  = writes_rd ? result_buff.wb_result : '0;

endmodule

`default_nettype wire
